// File: rtl/hwag_regs_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map and control word of the angle generator bus
// Shared by the register file and the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hwag_regs_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 8;

  // Configuration words
  localparam logic [ADDR_W-1:0] REG_FLT       = 8'h00;
  localparam logic [ADDR_W-1:0] REG_MIN_L     = 8'h01;
  localparam logic [ADDR_W-1:0] REG_MIN_H     = 8'h02;
  localparam logic [ADDR_W-1:0] REG_MAX_L     = 8'h03;
  localparam logic [ADDR_W-1:0] REG_MAX_H     = 8'h04;
  localparam logic [ADDR_W-1:0] REG_TOOTH_NUM = 8'h05;

  // Control, enables, flags and status
  localparam logic [ADDR_W-1:0] REG_CTRL_SET  = 8'h10;
  localparam logic [ADDR_W-1:0] REG_CTRL_CLR  = 8'h11;
  localparam logic [ADDR_W-1:0] REG_IE_SET    = 8'h12;
  localparam logic [ADDR_W-1:0] REG_IE_CLR    = 8'h13;
  localparam logic [ADDR_W-1:0] REG_FLAG      = 8'h14;
  localparam logic [ADDR_W-1:0] REG_P0_L      = 8'h15;
  localparam logic [ADDR_W-1:0] REG_P0_H      = 8'h16;
  localparam logic [ADDR_W-1:0] REG_TOOTH_VAL = 8'h17;

  // run sits at bit 0, filt_ena at bit 2
  typedef struct packed {
    logic filt_ena;
    logic edge_sel;
    logic run;
  } hwag_ctrl_t;

endpackage

// File: rtl/hwag_timing_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Period widths and interrupt flag positions of the engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hwag_timing_pkg;

  localparam int PERIOD_W = 24;

  // Last three tooth periods, p0 newest
  typedef struct packed {
    logic [PERIOD_W-1:0] p2;
    logic [PERIOD_W-1:0] p1;
    logic [PERIOD_W-1:0] p0;
  } period_set_t;

  // Bit positions in the flag word
  localparam int FLAG_EDGE = 0;
  localparam int FLAG_OVF  = 1;

endpackage

// File: rtl/hwag_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file: configuration, set/clear control, flags
// and registered readback for the 16-bit register bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hwag_regs #(
  parameter int TOOTH_W = 8
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  bus_we,
  input  logic                                  bus_re,
  input  logic [hwag_regs_pkg::ADDR_W-1:0]      bus_addr,
  input  logic [hwag_regs_pkg::DATA_W-1:0]      bus_wdata,
  output logic [hwag_regs_pkg::DATA_W-1:0]      bus_rdata,
  output hwag_regs_pkg::hwag_ctrl_t             ctrl,
  output logic [hwag_regs_pkg::DATA_W-1:0]      flt_val,
  output logic [hwag_timing_pkg::PERIOD_W-1:0]  min_period,
  output logic [hwag_timing_pkg::PERIOD_W-1:0]  max_period,
  output logic [TOOTH_W-1:0]                    tooth_num,
  output logic                                  tooth_load,
  output logic [TOOTH_W-1:0]                    load_val,
  input  logic [hwag_timing_pkg::PERIOD_W-1:0]  p0,
  input  logic [TOOTH_W-1:0]                    tooth_val,
  input  logic                                  edge_evt,
  input  logic                                  ovf_evt,
  output logic                                  hwagif
);
  import hwag_regs_pkg::*;
  import hwag_timing_pkg::*;

  localparam int CTRL_W = $bits(hwag_ctrl_t);
  localparam int HIGH_W = PERIOD_W - DATA_W;

  logic [DATA_W-1:0] min_l;
  logic [DATA_W-1:0] min_h;
  logic [DATA_W-1:0] max_l;
  logic [DATA_W-1:0] max_h;
  logic [DATA_W-1:0] tooth_num_q;
  logic [DATA_W-1:0] ie;
  logic [DATA_W-1:0] flags;
  logic [DATA_W-1:0] flag_evt;
  logic [DATA_W-1:0] flag_clr;

  // 24-bit window limits from split halves
  assign min_period = {min_h[HIGH_W-1:0], min_l};
  assign max_period = {max_h[HIGH_W-1:0], max_l};
  assign tooth_num  = tooth_num_q[TOOTH_W-1:0];

  // Tooth counter load, taken by the tracker in the same cycle
  assign tooth_load = bus_we && (bus_addr == REG_TOOTH_VAL);
  assign load_val   = bus_wdata[TOOTH_W-1:0];

  always_comb begin
    flag_evt            = '0;
    flag_evt[FLAG_EDGE] = edge_evt;
    flag_evt[FLAG_OVF]  = ovf_evt;
  end

  assign flag_clr = (bus_we && (bus_addr == REG_FLAG)) ? bus_wdata : '0;
  assign hwagif   = |flags;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl        <= '0;
      ie          <= '0;
      flt_val     <= '0;
      min_l       <= '0;
      min_h       <= '0;
      max_l       <= '0;
      max_h       <= '0;
      tooth_num_q <= '0;
    end else if (bus_we) begin
      case (bus_addr)
        REG_FLT:       flt_val     <= bus_wdata;
        REG_MIN_L:     min_l       <= bus_wdata;
        REG_MIN_H:     min_h       <= bus_wdata;
        REG_MAX_L:     max_l       <= bus_wdata;
        REG_MAX_H:     max_h       <= bus_wdata;
        REG_TOOTH_NUM: tooth_num_q <= bus_wdata;
        REG_CTRL_SET:  ctrl        <= ctrl | bus_wdata[CTRL_W-1:0];
        REG_CTRL_CLR:  ctrl        <= ctrl & ~bus_wdata[CTRL_W-1:0];
        REG_IE_SET:    ie          <= ie | bus_wdata;
        REG_IE_CLR:    ie          <= ie & ~bus_wdata;
        default: ;
      endcase
    end
  end

  // Sticky flags, a new event wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      flags <= (flags & ~flag_clr) | (flag_evt & ie);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bus_rdata <= '0;
    end else if (bus_re) begin
      case (bus_addr)
        REG_FLT:       bus_rdata <= flt_val;
        REG_MIN_L:     bus_rdata <= min_l;
        REG_MIN_H:     bus_rdata <= min_h;
        REG_MAX_L:     bus_rdata <= max_l;
        REG_MAX_H:     bus_rdata <= max_h;
        REG_TOOTH_NUM: bus_rdata <= tooth_num_q;
        REG_CTRL_SET:  bus_rdata <= DATA_W'(ctrl);
        REG_IE_SET:    bus_rdata <= ie;
        REG_FLAG:      bus_rdata <= flags;
        REG_P0_L:      bus_rdata <= p0[DATA_W-1:0];
        REG_P0_H:      bus_rdata <= DATA_W'(p0[PERIOD_W-1:DATA_W]);
        REG_TOOTH_VAL: bus_rdata <= DATA_W'(tooth_val);
        default:       bus_rdata <= '0;
      endcase
    end
  end

endmodule

// File: rtl/vr_filter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sensor input synchronizer, glitch filter and edge detect
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vr_filter #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             vr_in,
  input  hwag_regs_pkg::hwag_ctrl_t        ctrl,
  input  logic [hwag_regs_pkg::DATA_W-1:0] flt_val,
  output logic                             vr_out,
  output logic                             act_edge
);
  import hwag_regs_pkg::*;

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   sync_val;
  logic                   filt_q;
  logic [DATA_W-1:0]      stable_cnt;
  logic                   vr_prev;
  logic                   sel_edge;

  assign sync_val = sync_q[SYNC_STAGES-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], vr_in};
    end
  end

  // Level moves only after flt_val+1 steady cycles, so delay is fixed
  always_ff @(posedge clk) begin
    if (reset) begin
      filt_q     <= 1'b0;
      stable_cnt <= '0;
    end else if (sync_val == filt_q) begin
      stable_cnt <= '0;
    end else if (stable_cnt == flt_val) begin
      filt_q     <= sync_val;
      stable_cnt <= '0;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  assign vr_out = ctrl.filt_ena ? filt_q : sync_val;

  // edge_sel high picks the falling transition
  assign sel_edge = ctrl.edge_sel ? (vr_prev & ~vr_out) : (~vr_prev & vr_out);

  always_ff @(posedge clk) begin
    if (reset) begin
      vr_prev  <= 1'b0;
      act_edge <= 1'b0;
    end else begin
      vr_prev  <= vr_out;
      act_edge <= sel_edge;
    end
  end

endmodule

// File: rtl/period_capture.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tooth period counter with a three-deep period history
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module period_capture (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         run,
  input  logic                         act_edge,
  output hwag_timing_pkg::period_set_t periods,
  output logic                         ovf_evt
);
  import hwag_timing_pkg::*;

  logic [PERIOD_W-1:0] cnt;
  logic                cnt_top;

  assign cnt_top = &cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt     <= '0;
      periods <= '0;
      ovf_evt <= 1'b0;
    end else begin
      ovf_evt <= 1'b0;
      if (run && act_edge) begin
        // Period counts the edge cycle itself
        periods.p0 <= cnt_top ? cnt : cnt + 1'b1;
        periods.p1 <= periods.p0;
        periods.p2 <= periods.p1;
        cnt        <= '0;
      end else if (run && !cnt_top) begin
        cnt <= cnt + 1'b1;
        // Single pulse as the counter hits its ceiling
        if (cnt == {{(PERIOD_W-1){1'b1}}, 1'b0}) begin
          ovf_evt <= 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/period_check.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Window check of the three captured periods
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module period_check (
  input  hwag_timing_pkg::period_set_t         periods,
  input  logic [hwag_timing_pkg::PERIOD_W-1:0] min_period,
  input  logic [hwag_timing_pkg::PERIOD_W-1:0] max_period,
  output logic                                 window_ok
);
  logic p0_ok;
  logic p1_ok;
  logic p2_ok;

  // Lower bound exclusive, upper bound inclusive
  assign p0_ok = (periods.p0 > min_period) && (periods.p0 <= max_period);
  assign p1_ok = (periods.p1 > min_period) && (periods.p1 <= max_period);
  assign p2_ok = (periods.p2 > min_period) && (periods.p2 <= max_period);

  assign window_ok = p0_ok && p1_ok && p2_ok;

endmodule

// File: rtl/gap_search.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Missing-tooth detection on the captured periods
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gap_search (
  input  hwag_timing_pkg::period_set_t periods,
  output logic                         gap
);
  import hwag_timing_pkg::*;

  logic [PERIOD_W:0] p0_ext;
  logic [PERIOD_W:0] p1_dbl;
  logic [PERIOD_W:0] p2_dbl;

  // One extra bit so the doubled periods cannot wrap
  assign p0_ext = {1'b0, periods.p0};
  assign p1_dbl = {periods.p1, 1'b0};
  assign p2_dbl = {periods.p2, 1'b0};

  assign gap = (p0_ext >= p1_dbl) && (p0_ext >= p2_dbl) &&
               (periods.p1 != '0) && (periods.p2 != '0);

endmodule

// File: rtl/sync_tracker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start latch and wrapping tooth counter of the engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sync_tracker #(
  parameter int TOOTH_W = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               run,
  input  logic               act_edge,
  input  logic               window_ok,
  input  logic               gap,
  input  logic [TOOTH_W-1:0] tooth_num,
  input  logic               tooth_load,
  input  logic [TOOTH_W-1:0] load_val,
  output logic               hwag_start,
  output logic [TOOTH_W-1:0] tooth_val
);
  logic tooth_wrap;

  assign tooth_wrap = (tooth_val == tooth_num);

  // Periods seen here still belong to the previous edge
  always_ff @(posedge clk) begin
    if (reset) begin
      hwag_start <= 1'b0;
    end else if (!run) begin
      hwag_start <= 1'b0;
    end else if (act_edge && window_ok && gap) begin
      hwag_start <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tooth_val <= '0;
    end else if (tooth_load) begin
      tooth_val <= load_val;
    end else if (hwag_start && act_edge) begin
      tooth_val <= tooth_wrap ? '0 : tooth_val + 1'b1;
    end
  end

endmodule

// File: rtl/hwag_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Angle generator front end, bus registers plus sensor path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hwag_top #(
  parameter int TOOTH_W     = 8,
  parameter int SYNC_STAGES = 2
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             bus_we,
  input  logic                             bus_re,
  input  logic [hwag_regs_pkg::ADDR_W-1:0] bus_addr,
  input  logic [hwag_regs_pkg::DATA_W-1:0] bus_wdata,
  input  logic                             vr_in,
  output logic [hwag_regs_pkg::DATA_W-1:0] bus_rdata,
  output logic                             vr_out,
  output logic                             hwagif,
  output logic                             hwag_start
);
  import hwag_regs_pkg::*;
  import hwag_timing_pkg::*;

  hwag_ctrl_t          ctrl;
  logic [DATA_W-1:0]   flt_val;
  logic [PERIOD_W-1:0] min_period;
  logic [PERIOD_W-1:0] max_period;
  logic [TOOTH_W-1:0]  tooth_num;
  logic                tooth_load;
  logic [TOOTH_W-1:0]  load_val;
  logic [TOOTH_W-1:0]  tooth_val;
  logic                act_edge;
  logic                ovf_evt;
  logic                window_ok;
  logic                gap;
  period_set_t         periods;

  hwag_regs #(
    .TOOTH_W(TOOTH_W)
  ) hwag_regs_i (
    .clk       (clk),
    .reset     (reset),
    .bus_we    (bus_we),
    .bus_re    (bus_re),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .ctrl      (ctrl),
    .flt_val   (flt_val),
    .min_period(min_period),
    .max_period(max_period),
    .tooth_num (tooth_num),
    .tooth_load(tooth_load),
    .load_val  (load_val),
    .p0        (periods.p0),
    .tooth_val (tooth_val),
    .edge_evt  (act_edge),
    .ovf_evt   (ovf_evt),
    .hwagif    (hwagif)
  );

  vr_filter #(
    .SYNC_STAGES(SYNC_STAGES)
  ) vr_filter_i (
    .clk     (clk),
    .reset   (reset),
    .vr_in   (vr_in),
    .ctrl    (ctrl),
    .flt_val (flt_val),
    .vr_out  (vr_out),
    .act_edge(act_edge)
  );

  period_capture period_capture_i (
    .clk     (clk),
    .reset   (reset),
    .run     (ctrl.run),
    .act_edge(act_edge),
    .periods (periods),
    .ovf_evt (ovf_evt)
  );

  period_check period_check_i (
    .periods   (periods),
    .min_period(min_period),
    .max_period(max_period),
    .window_ok (window_ok)
  );

  gap_search gap_search_i (
    .periods(periods),
    .gap    (gap)
  );

  sync_tracker #(
    .TOOTH_W(TOOTH_W)
  ) sync_tracker_i (
    .clk       (clk),
    .reset     (reset),
    .run       (ctrl.run),
    .act_edge  (act_edge),
    .window_ok (window_ok),
    .gap       (gap),
    .tooth_num (tooth_num),
    .tooth_load(tooth_load),
    .load_val  (load_val),
    .hwag_start(hwag_start),
    .tooth_val (tooth_val)
  );

endmodule

// File: verif/hwag_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent rules on the top level that bind into hwag_top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hwag_props (
  input logic        clk,
  input logic        reset,
  input logic        hwagif,
  input logic [15:0] flags,
  input logic        act_edge,
  input logic        hwag_start,
  input logic        run
);
  int fail_cnt = 0;

  // Interrupt line is the OR of the flag word
  a_irq_or : assert property (@(posedge clk) disable iff (reset) hwagif == |flags)
    else begin
      $error("interrupt line differs from the OR of the flags");
      fail_cnt++;
    end

  a_edge_pulse : assert property (@(posedge clk) disable iff (reset) act_edge |=> !act_edge)
    else begin
      $error("active edge pulse longer than one cycle");
      fail_cnt++;
    end

  a_start_hold : assert property (@(posedge clk) disable iff (reset)
    (hwag_start && run) |=> (hwag_start || !run))
    else begin
      $error("start flag fell while run stayed high");
      fail_cnt++;
    end

endmodule

bind hwag_top hwag_props hwag_props_i (
  .clk       (clk),
  .reset     (reset),
  .hwagif    (hwagif),
  .flags     (hwag_regs_i.flags),
  .act_edge  (act_edge),
  .hwag_start(hwag_start),
  .run       (ctrl.run)
);

// File: verif/hwag_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the angle generator front end with bus tasks,
// a 36-minus-1 wheel model and checks on registers and sync
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hwag_tb;
  import hwag_regs_pkg::*;

  localparam int T     = 20;
  localparam int TEETH = 35;
  localparam int FLT   = 3;
  localparam int LIMIT = 5000;

  logic              clk;
  logic              reset;
  logic              bus_we;
  logic              bus_re;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_wdata;
  logic              vr_in;
  logic [DATA_W-1:0] bus_rdata;
  logic              vr_out;
  logic              hwagif;
  logic              hwag_start;

  logic wheel_on;
  logic wheel_idle;
  logic out_prev;
  int   tooth_idx;
  int   out_edges;
  int   tests;
  int   checks;
  int   errors;

  hwag_top hwag_top_i (
    .clk       (clk),
    .reset     (reset),
    .bus_we    (bus_we),
    .bus_re    (bus_re),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .vr_in     (vr_in),
    .bus_rdata (bus_rdata),
    .vr_out    (vr_out),
    .hwagif    (hwagif),
    .hwag_start(hwag_start)
  );

  always #20 clk = ~clk;

  // All stimulus and sampling happens 2 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_eq(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    tick();
    bus_we    = 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    bus_re   = 1'b1;
    bus_addr = addr;
    tick();
    bus_re   = 1'b0;
    data     = bus_rdata;
  endtask

  task automatic wait_vr_out(input logic level);
    int t;
    t = 0;
    while (vr_out !== level && t < LIMIT) begin
      tick();
      t++;
    end
    if (vr_out !== level) timeout_fail("vr_out to follow a steady level");
  endtask

  task automatic wait_hwagif();
    int t;
    t = 0;
    while (hwagif !== 1'b1 && t < LIMIT) begin
      tick();
      t++;
    end
    if (hwagif !== 1'b1) timeout_fail("the interrupt line to rise");
  endtask

  // Returns once the period set and start latch follow edge number n
  task automatic wait_out_edges(input int n);
    int t;
    t = 0;
    while (out_edges < n && t < LIMIT) begin
      tick();
      t++;
    end
    if (out_edges < n) timeout_fail("filtered sensor edges");
    repeat (3) tick();
  endtask

  task automatic glitch(input logic level);
    int w;
    w     = 1 + ($urandom % FLT);
    vr_in = level;
    repeat (w) tick();
    vr_in = ~level;
    repeat (10) begin
      tick();
      check_eq("vr_out during glitch", vr_out, !level);
    end
  endtask

  // 36-minus-1 wheel with a rising edge every T cycles and a gap after the last tooth
  always begin
    if (wheel_on !== 1'b1) begin
      wheel_idle = 1'b1;
      tick();
    end else begin
      wheel_idle = 1'b0;
      vr_in = 1'b1;
      repeat (T/2) tick();
      vr_in = 1'b0;
      repeat (T/2) tick();
      if (tooth_idx == TEETH-1) repeat (T) tick();
      tooth_idx = (tooth_idx + 1) % TEETH;
    end
  end

  // Counts rising edges of vr_out ahead of the stimulus
  always begin
    @(posedge clk);
    #1;
    if (vr_out && !out_prev) out_edges++;
    out_prev = vr_out;
  end

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] p_first;
    logic [ADDR_W-1:0] cfg_addr [6];
    int                cfg_val  [6];
    int                base;
    int                k;
    int                t;

    clk        = 1'b0;
    reset      = 1'b1;
    bus_we     = 1'b0;
    bus_re     = 1'b0;
    bus_addr   = '0;
    bus_wdata  = '0;
    vr_in      = 1'b0;
    wheel_on   = 1'b0;
    wheel_idle = 1'b1;
    out_prev   = 1'b0;
    tooth_idx  = 0;
    out_edges  = 0;
    tests      = 0;
    checks     = 0;
    errors     = 0;
    void'($urandom(32'h5fcd));
    repeat (10) tick();
    reset = 1'b0;

    cfg_addr = '{REG_FLT, REG_MIN_L, REG_MIN_H, REG_MAX_L, REG_MAX_H, REG_TOOTH_NUM};
    cfg_val  = '{FLT, T-1, 0, 2*T, 0, TEETH-1};
    foreach (cfg_addr[i]) bus_write(cfg_addr[i], DATA_W'(cfg_val[i]));
    foreach (cfg_addr[i]) begin
      bus_read(cfg_addr[i], rd);
      check_eq("config readback", rd, cfg_val[i]);
    end
    // Set run, edge_sel, filt_ena then clear run and edge_sel
    bus_write(REG_CTRL_SET, 16'h0007);
    bus_write(REG_CTRL_CLR, 16'h0003);
    bus_read(REG_CTRL_SET, rd);
    check_eq("control readback", rd, 4);
    bus_read(REG_CTRL_CLR, rd);
    check_eq("unmapped 0x11", rd, 0);
    bus_read(8'h20, rd);
    check_eq("unmapped 0x20", rd, 0);
    end_test("register readback");

    wait_vr_out(1'b0);
    repeat (5) glitch(1'b1);
    vr_in = 1'b1;
    wait_vr_out(1'b1);
    repeat (5) glitch(1'b0);
    vr_in = 1'b0;
    wait_vr_out(1'b0);
    end_test("filter");

    bus_write(REG_CTRL_SET, 16'h0001);
    base     = out_edges;
    wheel_on = 1'b1;
    wait_out_edges(base + 5);
    bus_read(REG_P0_L, rd);
    check_eq("normal tooth period", rd, T);
    bus_read(REG_P0_H, rd);
    check_eq("normal period high half", rd, 0);
    check_eq("start before gap", hwag_start, 0);
    wait_out_edges(base + TEETH + 1);
    bus_read(REG_P0_L, rd);
    check_eq("gap period", rd, 2*T);
    check_eq("start on gap edge", hwag_start, 0);
    end_test("period capture");

    wait_out_edges(base + TEETH + 2);
    check_eq("start one tooth after gap", hwag_start, 1);
    k = 40;
    wait_out_edges(base + TEETH + 2 + k);
    bus_read(REG_TOOTH_VAL, rd);
    check_eq("tooth counter", rd, k % TEETH);
    end_test("sync and tooth count");

    bus_write(REG_IE_SET, 16'h0001);
    wait_hwagif();
    bus_write(REG_FLAG, 16'h0001);
    check_eq("interrupt after flag clear", hwagif, 0);
    bus_write(REG_IE_CLR, 16'h0001);
    bus_write(REG_IE_SET, 16'h0002);
    wheel_on = 1'b0;
    t = 0;
    while (!wheel_idle && t < LIMIT) begin
      tick();
      t++;
    end
    if (!wheel_idle) timeout_fail("the wheel model to stop");
    // Drain the synchronizer, filter and edge stages
    repeat (12) tick();
    bus_read(REG_P0_L, p_first);
    repeat (3*T) tick();
    bus_read(REG_P0_L, rd);
    check_eq("period with sensor stopped", rd, p_first);
    bus_read(REG_FLAG, rd);
    check_eq("flags before overflow", rd, 0);
    check_eq("interrupt before overflow", hwagif, 0);
    end_test("interrupts");

    errors += hwag_top_i.hwag_props_i.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/hwag_regs_pkg.sv
rtl/hwag_timing_pkg.sv
rtl/hwag_regs.sv
rtl/vr_filter.sv
rtl/period_capture.sv
rtl/period_check.sv
rtl/gap_search.sv
rtl/sync_tracker.sv
rtl/hwag_top.sv
verif/hwag_props.sv
verif/hwag_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the angle generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hwag_tb -f list.f -o hwag_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/hwag_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
  exit 0
fi
exit 1
